//--- game_pkg.sv
/*
 * Memory game shared definitions
 * Vector types, FSM state encoding, the fixed color sequence
 * and the final round index for each level
 */
package game_pkg;

    // One-hot color, bit 0 is the first button and LED
    typedef logic [3:0] color_t;

    // Sequence index, also used as the round number
    typedef logic [3:0] addr_t;

    typedef logic [3:0] nibble_t;

    // Active-low segments, bit 6 is g and bit 0 is a
    typedef logic [6:0] seg7_t;

    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        INIT       = 4'd1,
        SHOW_STEP  = 4'd2,
        SHOW_GAP   = 4'd3,
        WAIT_MOVE  = 4'd4,
        CHECK      = 4'd5,
        NEXT_ROUND = 4'd6,
        WON        = 4'd7,
        LOST       = 4'd8
    } game_state_t;

    // Fixed game sequence, one entry per step
    localparam color_t SEQ_TABLE [16] = '{
        4'b0001, 4'b0100, 4'b0010, 4'b1000,
        4'b0100, 4'b0001, 4'b1000, 4'b0010,
        4'b0010, 4'b1000, 4'b0001, 4'b0100,
        4'b1000, 4'b0010, 4'b0100, 4'b0001
    };

    // Last round index for nivel_jogadas low and high
    localparam addr_t ROUNDS_SHORT = 4'd3;
    localparam addr_t ROUNDS_LONG  = 4'd15;

endpackage

//--- game_ctrl_if.sv
/*
 * Control to datapath link of the memory game
 * Commands from the FSM and status back from the play datapath
 */
`timescale 1ns/1ns

interface game_ctrl_if;

    // Commands
    logic clr_round;
    logic inc_round;
    logic clr_addr;
    logic inc_addr;
    logic latch_levels;
    logic show_led;

    // Conditions
    logic               last_addr;
    logic               last_round;
    logic               move_made;
    logic               move_ok;
    logic               lvl_time;
    game_pkg::addr_t    round;

    modport ctrl (
        output clr_round, inc_round, clr_addr, inc_addr, latch_levels, show_led,
        input  last_addr, last_round, move_made, move_ok
    );

    modport dp (
        input  clr_round, inc_round, clr_addr, inc_addr, latch_levels, show_led,
        output last_addr, last_round, move_made, move_ok, lvl_time, round
    );

endinterface

//--- play_datapath.sv
/*
 * Play datapath of the memory game
 * Level registers, round and address counters, button press
 * detection and the check of each move against the sequence
 */
`timescale 1ns/1ns

module play_datapath (
    input  logic               clock,
    input  logic               arst_n,
    input  game_pkg::color_t   botoes,
    input  logic               nivel_jogadas,
    input  logic               nivel_tempo,
    game_ctrl_if.dp            cif,
    output game_pkg::color_t   leds
);

    logic               lvl_rounds;
    logic               lvl_time_q;
    game_pkg::addr_t    round_q;
    game_pkg::addr_t    addr_q;
    game_pkg::addr_t    final_round;
    game_pkg::color_t   btn_prev;
    game_pkg::color_t   press_q;
    logic               move_made_q;

    // Levels are sampled once per game
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            lvl_rounds <= 1'b0;
            lvl_time_q <= 1'b0;
        end else if (cif.latch_levels) begin
            lvl_rounds <= nivel_jogadas;
            lvl_time_q <= nivel_tempo;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            round_q <= '0;
        end else if (cif.clr_round) begin
            round_q <= '0;
        end else if (cif.inc_round) begin
            round_q <= round_q + 4'd1;
        end
    end

    // Address walks the sequence in both the show and the play phase
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            addr_q <= '0;
        end else if (cif.clr_addr) begin
            addr_q <= '0;
        end else if (cif.inc_addr) begin
            addr_q <= addr_q + 4'd1;
        end
    end

    // Press is a step from all released to any pressed
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            btn_prev    <= '0;
            move_made_q <= 1'b0;
        end else begin
            btn_prev    <= botoes;
            move_made_q <= (btn_prev == '0) && (botoes != '0);
        end
    end

    // Button pattern of the press, held until the next one
    always_ff @(posedge clock) begin
        if ((btn_prev == '0) && (botoes != '0)) begin
            press_q <= botoes;
        end
    end

    assign final_round = lvl_rounds ? game_pkg::ROUNDS_LONG : game_pkg::ROUNDS_SHORT;

    assign cif.move_made  = move_made_q;
    assign cif.move_ok    = (press_q == game_pkg::SEQ_TABLE[addr_q]);
    assign cif.last_addr  = (addr_q == round_q);
    assign cif.last_round = (round_q == final_round);
    assign cif.lvl_time   = lvl_time_q;
    assign cif.round      = round_q;

    // Sequence color while a step is on show, dark otherwise
    assign leds = cif.show_led ? game_pkg::SEQ_TABLE[addr_q] : '0;

endmodule

//--- move_timer.sv
/*
 * Move timer of the memory game
 * One counter paces the show steps and measures the move timeout,
 * which is halved at the fast time level
 */
`timescale 1ns/1ns

module move_timer #(
    parameter int SHOW_CYCLES    = 4,
    parameter int TIMEOUT_CYCLES = 40
) (
    input  logic clock,
    input  logic arst_n,
    input  logic clr_timer,
    input  logic run_show,
    input  logic run_move,
    input  logic lvl_time,
    output logic show_done,
    output logic timeout
);

    // Wide enough for the longer of the two limits
    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + SHOW_CYCLES + 1);

    localparam logic [CNT_W-1:0] CNT_MAX   = '1;
    localparam logic [CNT_W-1:0] SHOW_LAST = CNT_W'(SHOW_CYCLES - 1);
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(TIMEOUT_CYCLES - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(TIMEOUT_CYCLES / 2 - 1);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] move_last;

    // lvl_time high selects the short timeout
    assign move_last = lvl_time ? HALF_LAST : FULL_LAST;

    // Saturates so a forgotten run cannot wrap back to a match
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (clr_timer) begin
            cnt <= '0;
        end else if ((run_show || run_move) && (cnt != CNT_MAX)) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            show_done <= 1'b0;
            timeout   <= 1'b0;
        end else begin
            show_done <= run_show && (cnt == SHOW_LAST);
            timeout   <= run_move && (cnt == move_last);
        end
    end

endmodule

//--- game_control.sv
/*
 * Control FSM of the memory game
 * Shows the sequence up to the current round, waits for the moves,
 * checks them and ends the game with a win or a loss
 */
`timescale 1ns/1ns

module game_control (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    iniciar,
    game_ctrl_if.ctrl               cif,
    input  logic                    show_done,
    input  logic                    timeout,
    output logic                    clr_timer,
    output logic                    run_show,
    output logic                    run_move,
    output logic                    ganhou,
    output logic                    perdeu,
    output logic                    pronto,
    output logic                    vez_jogador,
    output logic                    pulso_buzzer,
    output logic                    db_timeout,
    output game_pkg::game_state_t   state
);

    game_pkg::game_state_t state_nx;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= game_pkg::IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx         = state;
        cif.clr_round    = 1'b0;
        cif.inc_round    = 1'b0;
        cif.clr_addr     = 1'b0;
        cif.inc_addr     = 1'b0;
        cif.latch_levels = 1'b0;
        cif.show_led     = 1'b0;
        clr_timer        = 1'b0;
        run_show         = 1'b0;
        run_move         = 1'b0;

        unique case (state)
            game_pkg::IDLE: begin
                if (iniciar) state_nx = game_pkg::INIT;
            end
            game_pkg::INIT: begin
                cif.latch_levels = 1'b1;
                cif.clr_round    = 1'b1;
                cif.clr_addr     = 1'b1;
                clr_timer        = 1'b1;
                state_nx         = game_pkg::SHOW_STEP;
            end
            game_pkg::SHOW_STEP: begin
                cif.show_led = 1'b1;
                run_show     = 1'b1;
                if (show_done) begin
                    clr_timer = 1'b1;
                    state_nx  = game_pkg::SHOW_GAP;
                end
            end
            // Dark pause after each step; the last one hands over to the player
            game_pkg::SHOW_GAP: begin
                run_show = 1'b1;
                if (show_done) begin
                    clr_timer = 1'b1;
                    if (cif.last_addr) begin
                        cif.clr_addr = 1'b1;
                        state_nx     = game_pkg::WAIT_MOVE;
                    end else begin
                        cif.inc_addr = 1'b1;
                        state_nx     = game_pkg::SHOW_STEP;
                    end
                end
            end
            game_pkg::WAIT_MOVE: begin
                run_move = 1'b1;
                // A press wins over a timeout in the same cycle
                if (cif.move_made) begin
                    state_nx = cif.move_ok ? game_pkg::CHECK : game_pkg::LOST;
                end else if (timeout) begin
                    state_nx = game_pkg::LOST;
                end
            end
            game_pkg::CHECK: begin
                clr_timer = 1'b1;
                if (cif.last_addr) begin
                    state_nx = cif.last_round ? game_pkg::WON : game_pkg::NEXT_ROUND;
                end else begin
                    cif.inc_addr = 1'b1;
                    state_nx     = game_pkg::WAIT_MOVE;
                end
            end
            game_pkg::NEXT_ROUND: begin
                cif.inc_round = 1'b1;
                cif.clr_addr  = 1'b1;
                clr_timer     = 1'b1;
                state_nx      = game_pkg::SHOW_STEP;
            end
            game_pkg::WON, game_pkg::LOST: begin
                if (iniciar) state_nx = game_pkg::INIT;
            end
            default: state_nx = game_pkg::IDLE;
        endcase
    end

    // Buzzer pulse and timeout cause
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pulso_buzzer <= 1'b0;
            db_timeout   <= 1'b0;
        end else begin
            pulso_buzzer <= (state == game_pkg::WAIT_MOVE) && cif.move_made;
            if (state == game_pkg::INIT) begin
                db_timeout <= 1'b0;
            end else if ((state == game_pkg::WAIT_MOVE) && timeout && !cif.move_made) begin
                db_timeout <= 1'b1;
            end
        end
    end

    assign ganhou      = (state == game_pkg::WON);
    assign perdeu      = (state == game_pkg::LOST);
    assign pronto      = ganhou || perdeu;
    assign vez_jogador = (state == game_pkg::WAIT_MOVE);

endmodule

//--- hex7seg.sv
/*
 * Hex digit to seven-segment decoder, active-low outputs
 */
`timescale 1ns/1ns

module hex7seg (
    input  game_pkg::nibble_t hexa,
    output game_pkg::seg7_t   display
);

    // Segment order gfedcba
    always_comb begin
        unique case (hexa)
            4'h0: display = 7'b1000000;
            4'h1: display = 7'b1111001;
            4'h2: display = 7'b0100100;
            4'h3: display = 7'b0110000;
            4'h4: display = 7'b0011001;
            4'h5: display = 7'b0010010;
            4'h6: display = 7'b0000010;
            4'h7: display = 7'b1111000;
            4'h8: display = 7'b0000000;
            4'h9: display = 7'b0010000;
            4'hA: display = 7'b0001000;
            4'hB: display = 7'b0000011;
            4'hC: display = 7'b1000110;
            4'hD: display = 7'b0100001;
            4'hE: display = 7'b0000110;
            default: display = 7'b0001110;
        endcase
    end

endmodule

//--- memory_game.sv
/*
 * Memory game top level
 * Wires the play datapath, move timer and control FSM together,
 * and drives the state and round displays
 */
`timescale 1ns/1ns

module memory_game #(
    parameter int SHOW_CYCLES    = 4,
    parameter int TIMEOUT_CYCLES = 40
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               iniciar,
    input  game_pkg::color_t   botoes,
    input  logic               nivel_jogadas,
    input  logic               nivel_tempo,
    output logic               ganhou,
    output logic               perdeu,
    output logic               pronto,
    output logic               vez_jogador,
    output game_pkg::color_t   leds,
    output logic               pulso_buzzer,
    output game_pkg::seg7_t    db_estado,
    output game_pkg::seg7_t    db_rodada,
    output logic               db_timeout
);

    game_ctrl_if cif ();

    logic                   clr_timer;
    logic                   run_show;
    logic                   run_move;
    logic                   show_done;
    logic                   timeout;
    game_pkg::game_state_t  state;
    game_pkg::color_t       seq_leds;

    play_datapath i_play_datapath (
        .clock         ( clock         ),
        .arst_n        ( arst_n        ),
        .botoes        ( botoes        ),
        .nivel_jogadas ( nivel_jogadas ),
        .nivel_tempo   ( nivel_tempo   ),
        .cif           ( cif.dp        ),
        .leds          ( seq_leds      )
    );

    move_timer #(
        .SHOW_CYCLES    ( SHOW_CYCLES    ),
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES )
    ) i_move_timer (
        .clock     ( clock        ),
        .arst_n    ( arst_n       ),
        .clr_timer ( clr_timer    ),
        .run_show  ( run_show     ),
        .run_move  ( run_move     ),
        .lvl_time  ( cif.lvl_time ),
        .show_done ( show_done    ),
        .timeout   ( timeout      )
    );

    game_control i_game_control (
        .clock        ( clock        ),
        .arst_n       ( arst_n       ),
        .iniciar      ( iniciar      ),
        .cif          ( cif.ctrl     ),
        .show_done    ( show_done    ),
        .timeout      ( timeout      ),
        .clr_timer    ( clr_timer    ),
        .run_show     ( run_show     ),
        .run_move     ( run_move     ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .pronto       ( pronto       ),
        .vez_jogador  ( vez_jogador  ),
        .pulso_buzzer ( pulso_buzzer ),
        .db_timeout   ( db_timeout   ),
        .state        ( state        )
    );

    // Player's turn echoes the buttons on the LEDs
    assign leds = vez_jogador ? botoes : seq_leds;

    hex7seg i_display_estado (
        .hexa    ( game_pkg::nibble_t'(state) ),
        .display ( db_estado                  )
    );

    hex7seg i_display_rodada (
        .hexa    ( cif.round ),
        .display ( db_rodada )
    );

endmodule

//--- memory_game_props.sv
/*
 * Memory game output properties
 * Concurrent assertions on the end flags, buzzer and LEDs
 */
`timescale 1ns/1ns

module memory_game_props (
    input logic             clock,
    input logic             arst_n,
    input logic             iniciar,
    input logic             ganhou,
    input logic             perdeu,
    input logic             pronto,
    input logic             vez_jogador,
    input logic             pulso_buzzer,
    input game_pkg::color_t leds
);

    int fail_count = 0;

    // A result stays as it is until the next game starts
    a_end_exclusive: assert property (
        @(posedge clock) disable iff (!arst_n)
        (ganhou || perdeu) && !iniciar |=> $stable(ganhou) && $stable(perdeu)
    ) else begin
        $error("ganhou or perdeu changed without iniciar");
        fail_count++;
    end

    a_buzzer_single: assert property (
        @(posedge clock) disable iff (!arst_n) pulso_buzzer |=> !pulso_buzzer
    ) else begin
        $error("pulso_buzzer longer than one cycle");
        fail_count++;
    end

    // At most one color lit
    a_leds_onehot: assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(leds)
    ) else begin
        $error("leds not one-hot or zero");
        fail_count++;
    end

    // Game ends only out of the player's turn
    a_pronto_end: assert property (
        @(posedge clock) disable iff (!arst_n)
        $rose(pronto) |-> $past(vez_jogador) || $past(vez_jogador, 2)
    ) else begin
        $error("pronto rose without a preceding player turn");
        fail_count++;
    end

endmodule

//--- tb_memory_game.sv
/*
 * Testbench for the memory game
 * Plays a table of games, checks the LED sequence, the displays
 * and the end flags against the expected values
 */
`timescale 1ns/1ns

module tb_memory_game;

    localparam int SHOW_CYCLES    = 2;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int WAIT_LIMIT     = 200;

    // Wait selectors
    localparam int W_TURN  = 0;
    localparam int W_BUZZ  = 1;
    localparam int W_DONE  = 2;
    localparam int W_CLEAR = 3;

    typedef enum logic [1:0] {FAIL_NONE, FAIL_WRONG, FAIL_TIMEOUT} fail_kind_t;

    typedef struct packed {
        logic            nivel_jogadas;
        logic            nivel_tempo;
        game_pkg::addr_t fail_round;
        fail_kind_t      fail_kind;
        logic            exp_won;
    } game_row_t;

    localparam int NUM_ROWS = 4;
    localparam game_row_t GAMES [NUM_ROWS] = '{
        '{1'b0, 1'b0, 4'd0, FAIL_NONE,    1'b1},
        '{1'b0, 1'b0, 4'd2, FAIL_WRONG,   1'b0},
        '{1'b1, 1'b1, 4'd1, FAIL_TIMEOUT, 1'b0},
        '{1'b1, 1'b0, 4'd0, FAIL_NONE,    1'b1}
    };

    // Active-low gfedcba patterns of the hex digits
    localparam game_pkg::seg7_t SEG_DIGIT [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    logic             clock;
    logic             arst_n;
    logic             iniciar;
    game_pkg::color_t botoes;
    logic             nivel_jogadas;
    logic             nivel_tempo;
    logic             ganhou;
    logic             perdeu;
    logic             pronto;
    logic             vez_jogador;
    game_pkg::color_t leds;
    logic             pulso_buzzer;
    game_pkg::seg7_t  db_estado;
    game_pkg::seg7_t  db_rodada;
    logic             db_timeout;

    int value_errors  = 0;
    int other_errors  = 0;
    int assert_errors = 0;
    bit aborted       = 1'b0;

    memory_game #(
        .SHOW_CYCLES    ( SHOW_CYCLES    ),
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES )
    ) i_memory_game (
        .clock         ( clock         ),
        .arst_n        ( arst_n        ),
        .iniciar       ( iniciar       ),
        .botoes        ( botoes        ),
        .nivel_jogadas ( nivel_jogadas ),
        .nivel_tempo   ( nivel_tempo   ),
        .ganhou        ( ganhou        ),
        .perdeu        ( perdeu        ),
        .pronto        ( pronto        ),
        .vez_jogador   ( vez_jogador   ),
        .leds          ( leds          ),
        .pulso_buzzer  ( pulso_buzzer  ),
        .db_estado     ( db_estado     ),
        .db_rodada     ( db_rodada     ),
        .db_timeout    ( db_timeout    )
    );

    bind memory_game memory_game_props i_memory_game_props (
        .clock        ( clock        ),
        .arst_n       ( arst_n       ),
        .iniciar      ( iniciar      ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .pronto       ( pronto       ),
        .vez_jogador  ( vez_jogador  ),
        .pulso_buzzer ( pulso_buzzer ),
        .leds         ( leds         )
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic check_color(input string name, input game_pkg::color_t got,
                               input game_pkg::color_t exp);
        if (!aborted && got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_seg(input string name, input game_pkg::seg7_t got,
                             input game_pkg::seg7_t exp);
        if (!aborted && got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (!aborted && got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    function automatic logic flag_of(input int sel);
        case (sel)
            W_TURN:  return vez_jogador;
            W_BUZZ:  return pulso_buzzer;
            W_DONE:  return pronto;
            default: return !pronto;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // Samples on the falling edge, away from input changes
    task automatic wait_for(input string what, input int sel, input int limit,
                            output int cycles);
        cycles = 0;
        @(negedge clock);
        while (!aborted && !flag_of(sel)) begin
            if (cycles == limit) begin
                other_errors++;
                aborted = 1'b1;
                $display("Timeout: %s did not happen within %0d cycles", what, limit);
            end else begin
                cycles++;
                @(negedge clock);
            end
        end
    endtask

    // Each dark to lit step of the LEDs is one shown color
    task automatic watch_show(input int r);
        game_pkg::color_t prev;
        int shown;
        int cycles;
        bit done;
        prev   = '0;
        shown  = 0;
        cycles = 0;
        done   = 1'b0;
        while (!aborted && !done) begin
            @(negedge clock);
            if (vez_jogador) begin
                done = 1'b1;
            end else if (cycles == WAIT_LIMIT) begin
                other_errors++;
                aborted = 1'b1;
                $display("Timeout: show phase of round %0d did not end", r);
            end else begin
                if ((leds != '0) && (prev == '0)) begin
                    check_color("leds", leds, game_pkg::SEQ_TABLE[shown[3:0]]);
                    shown++;
                end
                prev = leds;
                cycles++;
            end
        end
        if (!aborted && shown != r + 1) begin
            other_errors++;
            $display("Round %0d showed %0d steps instead of %0d", r, shown, r + 1);
        end
    endtask

    task automatic press(input game_pkg::color_t color);
        int cycles;
        repeat ($urandom % 4 + 1) next_cycle();
        botoes = color;
        @(negedge clock);
        check_color("leds", leds, color);
        next_cycle();
        botoes = '0;
        wait_for("buzzer pulse", W_BUZZ, 4, cycles);
    endtask

    task automatic start_game(input logic nj, input logic nt);
        int cycles;
        next_cycle();
        nivel_jogadas = nj;
        nivel_tempo   = nt;
        iniciar       = 1'b1;
        next_cycle();
        iniciar = 1'b0;
        wait_for("pronto to clear", W_CLEAR, 4, cycles);
        check_flag("ganhou", ganhou, 1'b0);
        check_flag("perdeu", perdeu, 1'b0);
    endtask

    task automatic play_game(input game_row_t g);
        int last;
        int limit;
        int cycles;
        bit failed;
        game_pkg::color_t exp_color;
        last   = g.nivel_jogadas ? 15 : 3;
        limit  = g.nivel_tempo ? TIMEOUT_CYCLES / 2 : TIMEOUT_CYCLES;
        failed = 1'b0;
        start_game(g.nivel_jogadas, g.nivel_tempo);
        for (int r = 0; r <= last && !failed && !aborted; r++) begin
            watch_show(r);
            check_seg("db_rodada", db_rodada, SEG_DIGIT[r]);
            check_seg("db_estado", db_estado, SEG_DIGIT[4]);
            for (int k = 0; k <= r && !failed && !aborted; k++) begin
                exp_color = game_pkg::SEQ_TABLE[k];
                if (r == int'(g.fail_round) && k == 0 && g.fail_kind == FAIL_WRONG) begin
                    press({exp_color[2:0], exp_color[3]});
                    failed = 1'b1;
                end else if (r == int'(g.fail_round) && k == 0 &&
                             g.fail_kind == FAIL_TIMEOUT) begin
                    wait_for("move timeout", W_DONE, limit + 2, cycles);
                    if (!aborted && cycles < limit - 2) begin
                        other_errors++;
                        $display("Move timeout came after %0d cycles, expected %0d",
                                 cycles, limit);
                    end
                    failed = 1'b1;
                end else begin
                    press(exp_color);
                    if (k < r) wait_for("next move", W_TURN, 8, cycles);
                end
            end
        end
        wait_for("game end", W_DONE, 3, cycles);
        check_flag("ganhou", ganhou, g.exp_won);
        check_flag("perdeu", perdeu, !g.exp_won);
        check_flag("db_timeout", db_timeout, g.fail_kind == FAIL_TIMEOUT);
        check_seg("db_estado", db_estado, SEG_DIGIT[g.exp_won ? 7 : 8]);
        check_seg("db_rodada", db_rodada,
                  SEG_DIGIT[g.exp_won ? last : int'(g.fail_round)]);
    endtask

    initial begin
        void'($urandom(32'ha96c));
        arst_n        = 1'b0;
        iniciar       = 1'b0;
        botoes        = '0;
        nivel_jogadas = 1'b0;
        nivel_tempo   = 1'b0;
        repeat (5) @(posedge clock);
        #2 arst_n = 1'b1;
        @(negedge clock);
        check_flag("ganhou", ganhou, 1'b0);
        check_flag("perdeu", perdeu, 1'b0);
        check_flag("pronto", pronto, 1'b0);
        check_flag("vez_jogador", vez_jogador, 1'b0);
        check_flag("pulso_buzzer", pulso_buzzer, 1'b0);
        check_flag("db_timeout", db_timeout, 1'b0);
        check_color("leds", leds, '0);
        check_seg("db_estado", db_estado, SEG_DIGIT[0]);
        for (int i = 0; i < NUM_ROWS && !aborted; i++) begin
            play_game(GAMES[i]);
        end
        // Restart after the long game
        if (!aborted) start_game(1'b0, 1'b0);
        assert_errors = i_memory_game.i_memory_game_props.fail_count;
        $display("Value errors: %0d, other errors: %0d, assertion errors: %0d",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
game_pkg.sv
game_ctrl_if.sv
play_datapath.sv
move_timer.sv
game_control.sv
hex7seg.sv
memory_game.sv
memory_game_props.sv
tb_memory_game.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory game testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_memory_game \
    -f vlog.f -o sim_memory_game \
    && ./obj_dir/sim_memory_game > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
